/* flist.f */
rtl/setup_pkg.sv
rtl/setup_msg_parser.sv
rtl/conn_fifo.sv
rtl/conn_launcher.sv
rtl/setup_handler.sv
verification/tb_setup_handler.sv

/* rtl/conn_fifo.sv */
`default_nettype none
`timescale 1ns/1ns

module conn_fifo
    import setup_pkg::*;
(
     input  wire logic      clk
    ,input  wire logic      rst_n

    ,input  wire logic      rec_in_val
    ,input  conn_record_t   rec_in
    ,output logic           rec_in_rdy

    ,output logic           rec_out_val
    ,output conn_record_t   rec_out
    ,input  wire logic      rec_out_rdy
);

    conn_record_t           mem [CONN_FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_CNT_W-1:0]  count;

    logic                   push;
    logic                   pop;

    assign rec_in_rdy  = (count != FIFO_CNT_W'(CONN_FIFO_DEPTH));
    assign rec_out_val = (count != '0);
    assign rec_out     = mem[rd_ptr];

    assign push = rec_in_val & rec_in_rdy;
    assign pop  = rec_out_val & rec_out_rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rec_in;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/conn_launcher.sv */
`default_nettype none
`timescale 1ns/1ns

module conn_launcher
    import setup_pkg::*;
(
     input  wire logic                  clk
    ,input  wire logic                  rst_n

    ,input  wire logic                  rec_out_val
    ,input  conn_record_t               rec_out
    ,output logic                       rec_out_rdy

    ,output logic                       app_mem_wr_req
    ,output logic [FLOWID_W-1:0]        app_mem_wr_addr
    ,output app_cntxt_t                 app_mem_wr_data

    ,output logic                       send_loop_q_wr_req
    ,output send_q_t                    send_loop_q_wr_data

    ,output logic                       recv_loop_q_wr_req
    ,output logic [FLOWID_W-1:0]        recv_loop_q_wr_flowid

    ,output logic                       setup_done
    ,output client_dir_e                bench_dir
);

    logic launch;

    assign rec_out_rdy = 1'b1;      // One record per cycle
    assign launch      = rec_out_val & rec_out_rdy;

    // ============================================================
    // Write strobes and status
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            app_mem_wr_req     <= 1'b0;
            send_loop_q_wr_req <= 1'b0;
            recv_loop_q_wr_req <= 1'b0;
            setup_done         <= 1'b0;
            bench_dir          <= DIR_SEND;
        end else begin
            app_mem_wr_req     <= launch;
            send_loop_q_wr_req <= launch & (rec_out.dir == DIR_SEND);
            recv_loop_q_wr_req <= launch & (rec_out.dir == DIR_RECV);
            if (launch) begin
                bench_dir <= rec_out.dir;
            end
            if (launch && rec_out.last_conn) begin
                setup_done <= 1'b1;     // Sticky
            end
        end
    end

    // Payload follows the strobes
    always_ff @(posedge clk) begin
        if (launch) begin
            app_mem_wr_addr                  <= rec_out.flowid;
            app_mem_wr_data.target_bytes     <= rec_out.target_bytes;
            app_mem_wr_data.dir              <= rec_out.dir;
            send_loop_q_wr_data.flowid       <= rec_out.flowid;
            send_loop_q_wr_data.target_bytes <= rec_out.target_bytes;
            recv_loop_q_wr_flowid            <= rec_out.flowid;
        end
    end

endmodule

`default_nettype wire

/* rtl/setup_handler.sv */
`default_nettype none
`timescale 1ns/1ns

module setup_handler
    import setup_pkg::*;
(
     input  wire logic                  clk
    ,input  wire logic                  rst_n

    ,input  wire logic                  setup_q_empty
    ,input  wire logic [FLOWID_W-1:0]   setup_q_flowid
    ,output logic                       setup_q_rd_req

    ,input  wire logic                  noc_in_val
    ,input  setup_msg_t                 noc_in_data
    ,output logic                       noc_in_rdy

    ,output logic                       noc_out_val
    ,output setup_msg_t                 noc_out_data
    ,input  wire logic                  noc_out_rdy

    ,output logic                       app_mem_wr_req
    ,output logic [FLOWID_W-1:0]        app_mem_wr_addr
    ,output app_cntxt_t                 app_mem_wr_data

    ,output logic                       send_loop_q_wr_req
    ,output send_q_t                    send_loop_q_wr_data

    ,output logic                       recv_loop_q_wr_req
    ,output logic [FLOWID_W-1:0]        recv_loop_q_wr_flowid

    ,output logic                       setup_done
    ,output client_dir_e                bench_dir
);

    logic           rec_in_val;
    conn_record_t   rec_in;
    logic           rec_in_rdy;

    logic           rec_out_val;
    conn_record_t   rec_out;
    logic           rec_out_rdy;

    setup_msg_parser msg_parser_i (
         .clk               (clk                )
        ,.rst_n             (rst_n              )
        ,.setup_q_empty     (setup_q_empty      )
        ,.setup_q_flowid    (setup_q_flowid     )
        ,.setup_q_rd_req    (setup_q_rd_req     )
        ,.noc_in_val        (noc_in_val         )
        ,.noc_in_data       (noc_in_data        )
        ,.noc_in_rdy        (noc_in_rdy         )
        ,.noc_out_val       (noc_out_val        )
        ,.noc_out_data      (noc_out_data       )
        ,.noc_out_rdy       (noc_out_rdy        )
        ,.rec_in_val        (rec_in_val         )
        ,.rec_in            (rec_in             )
        ,.rec_in_rdy        (rec_in_rdy         )
    );

    conn_fifo conn_fifo_i (
         .clk               (clk                )
        ,.rst_n             (rst_n              )
        ,.rec_in_val        (rec_in_val         )
        ,.rec_in            (rec_in             )
        ,.rec_in_rdy        (rec_in_rdy         )
        ,.rec_out_val       (rec_out_val        )
        ,.rec_out           (rec_out            )
        ,.rec_out_rdy       (rec_out_rdy        )
    );

    conn_launcher conn_launcher_i (
         .clk                   (clk                    )
        ,.rst_n                 (rst_n                  )
        ,.rec_out_val           (rec_out_val            )
        ,.rec_out               (rec_out                )
        ,.rec_out_rdy           (rec_out_rdy            )
        ,.app_mem_wr_req        (app_mem_wr_req         )
        ,.app_mem_wr_addr       (app_mem_wr_addr        )
        ,.app_mem_wr_data       (app_mem_wr_data        )
        ,.send_loop_q_wr_req    (send_loop_q_wr_req     )
        ,.send_loop_q_wr_data   (send_loop_q_wr_data    )
        ,.recv_loop_q_wr_req    (recv_loop_q_wr_req     )
        ,.recv_loop_q_wr_flowid (recv_loop_q_wr_flowid  )
        ,.setup_done            (setup_done             )
        ,.bench_dir             (bench_dir              )
    );

endmodule

`default_nettype wire

/* rtl/setup_msg_parser.sv */
`default_nettype none
`timescale 1ns/1ns

module setup_msg_parser
    import setup_pkg::*;
(
     input  wire logic                  clk
    ,input  wire logic                  rst_n

    ,input  wire logic                  setup_q_empty
    ,input  wire logic [FLOWID_W-1:0]   setup_q_flowid
    ,output logic                       setup_q_rd_req

    ,input  wire logic                  noc_in_val
    ,input  setup_msg_t                 noc_in_data
    ,output logic                       noc_in_rdy

    ,output logic                       noc_out_val
    ,output setup_msg_t                 noc_out_data
    ,input  wire logic                  noc_out_rdy

    ,output logic                       rec_in_val
    ,output conn_record_t               rec_in
    ,input  wire logic                  rec_in_rdy
);

    parser_state_e  state_q;
    parser_state_e  state_d;
    conn_record_t   rec_q;

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d        = state_q;
        noc_in_rdy     = 1'b0;
        noc_out_val    = 1'b0;
        rec_in_val     = 1'b0;
        setup_q_rd_req = 1'b0;

        case (state_q)
            IDLE: begin
                noc_in_rdy = ~setup_q_empty;     // Only take work with a flow id waiting
                if (noc_in_val && noc_in_rdy && (noc_in_data.msg_type == SETUP_REQ)) begin
                    setup_q_rd_req = 1'b1;
                    state_d        = CONFIRM;
                end
            end
            CONFIRM: begin
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_d = PUSH;
                end
            end
            PUSH: begin
                // Record goes out after the confirm so both orders agree
                rec_in_val = 1'b1;
                if (rec_in_rdy) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ============================================================
    // Record register
    // ============================================================
    always_ff @(posedge clk) begin
        if (setup_q_rd_req) begin
            rec_q.flowid       <= setup_q_flowid;
            rec_q.dir          <= noc_in_data.dir;
            rec_q.target_bytes <= noc_in_data.target_bytes;
            rec_q.last_conn    <= noc_in_data.last_conn;
        end
    end

    assign rec_in = rec_q;

    // Confirm echoes the request with the assigned flow id
    always_comb begin
        noc_out_data              = '0;
        noc_out_data.msg_type     = SETUP_CONFIRM;
        noc_out_data.flowid       = rec_q.flowid;
        noc_out_data.dir          = rec_q.dir;
        noc_out_data.last_conn    = rec_q.last_conn;
        noc_out_data.target_bytes = rec_q.target_bytes;
    end

endmodule

`default_nettype wire

/* rtl/setup_pkg.sv */
`default_nettype none

package setup_pkg;

    // ============================================================
    // Widths and sizes
    // ============================================================
    localparam int FLOWID_W        = 8;
    localparam int NOC_DATA_W      = 64;
    localparam int TARGET_W        = 32;
    localparam int MSG_TYPE_W      = 4;

    localparam int CONN_FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W      = $clog2(CONN_FIFO_DEPTH);
    localparam int FIFO_CNT_W      = $clog2(CONN_FIFO_DEPTH + 1);

    // Unused flit bits below the header fields
    localparam int MSG_PAD_W = NOC_DATA_W - MSG_TYPE_W - FLOWID_W - 1 - 1 - TARGET_W;

    // ============================================================
    // Encodings
    // ============================================================
    typedef enum logic [MSG_TYPE_W-1:0] {
        SETUP_REQ     = 4'h1,
        SETUP_CONFIRM = 4'h2
    } msg_type_e;

    typedef enum logic {
        DIR_SEND = 1'b0,
        DIR_RECV = 1'b1
    } client_dir_e;

    typedef enum logic [1:0] {
        IDLE,
        CONFIRM,
        PUSH
    } parser_state_e;

    // ============================================================
    // Message and record layouts
    // ============================================================
    typedef struct packed {
        msg_type_e                  msg_type;
        logic [FLOWID_W-1:0]        flowid;
        client_dir_e                dir;
        logic                       last_conn;
        logic [TARGET_W-1:0]        target_bytes;
        logic [MSG_PAD_W-1:0]       padding;
    } setup_msg_t;

    typedef struct packed {
        logic [FLOWID_W-1:0]        flowid;
        client_dir_e                dir;
        logic [TARGET_W-1:0]        target_bytes;
        logic                       last_conn;
    } conn_record_t;

    // Per-flow entry in application memory
    typedef struct packed {
        logic [TARGET_W-1:0]        target_bytes;
        client_dir_e                dir;
    } app_cntxt_t;

    typedef struct packed {
        logic [FLOWID_W-1:0]        flowid;
        logic [TARGET_W-1:0]        target_bytes;
    } send_q_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the setup handler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_setup_handler -Mdir "$BUILD_DIR" -o tb_setup_handler \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_setup_handler" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* verification/tb_setup_handler.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_setup_handler
    import setup_pkg::*;
();

    localparam int NUM_REQ    = 40;
    localparam int WAIT_LIMIT = 2000;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   setup_q_empty;
    logic [FLOWID_W-1:0]    setup_q_flowid;
    logic                   setup_q_rd_req;
    logic                   noc_in_val;
    setup_msg_t             noc_in_data;
    logic                   noc_in_rdy;
    logic                   noc_out_val;
    setup_msg_t             noc_out_data;
    logic                   noc_out_rdy;
    logic                   app_mem_wr_req;
    logic [FLOWID_W-1:0]    app_mem_wr_addr;
    app_cntxt_t             app_mem_wr_data;
    logic                   send_loop_q_wr_req;
    send_q_t                send_loop_q_wr_data;
    logic                   recv_loop_q_wr_req;
    logic [FLOWID_W-1:0]    recv_loop_q_wr_flowid;
    logic                   setup_done;
    client_dir_e            bench_dir;

    integer                 seed = 69055;
    logic                   bp_on = 1'b0;
    logic                   in_fire = 1'b0;     // Input handshake seen on the last rising edge
    logic                   timed_out = 1'b0;
    int                     errors = 0;
    int                     start_errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    string                  cur_test = "setup";

    // ============================================================
    // Reference model state
    // ============================================================
    logic [FLOWID_W-1:0]    fid_q[$];           // Setup queue as seen by the DUT
    setup_msg_t             exp_conf[$];
    conn_record_t           exp_launch[$];
    client_dir_e            exp_dir = DIR_SEND;
    logic                   done_exp = 1'b0;

    setup_handler setup_handler_i (.*);

    always #20 clk = ~clk;

    task automatic check_val(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("[ERROR] %s: %s", cur_test, what);
            errors++;
        end
    endtask

    task automatic report_timeout(input string why);
        $display("%s: %s", cur_test, why);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        start_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, errors - start_errors);
        end
    endtask

    // Setup queue port and output back-pressure
    always @(negedge clk) begin : queue_port
        logic [31:0] rnd;
        rnd            = $random(seed);
        setup_q_empty  = (fid_q.size() == 0);
        setup_q_flowid = (fid_q.size() == 0) ? rnd[FLOWID_W-1:0] : fid_q[0];
        noc_out_rdy    = bp_on ? ((rnd % 32'd100) < 32'd30) : 1'b1;
    end

    // ============================================================
    // Monitor, samples the values that the rising edge uses
    // ============================================================
    always @(posedge clk) begin : monitor
        setup_msg_t     conf;
        conn_record_t   rec;
        in_fire = rst_n && noc_in_val && noc_in_rdy;
        if (rst_n) begin
            check_val("queue pop", 64'(in_fire && (noc_in_data.msg_type == SETUP_REQ)),
                      64'(setup_q_rd_req));
            if (setup_q_empty || exp_conf.size() != 0) begin
                check_val("noc_in_rdy", 64'd0, 64'(noc_in_rdy));    // No flow id or confirm pending
            end
            if (in_fire && (noc_in_data.msg_type == SETUP_REQ) && (fid_q.size() != 0)) begin
                conf              = '0;
                conf.msg_type     = SETUP_CONFIRM;
                conf.flowid       = fid_q[0];
                conf.dir          = noc_in_data.dir;
                conf.last_conn    = noc_in_data.last_conn;
                conf.target_bytes = noc_in_data.target_bytes;
                exp_conf.push_back(conf);
            end
            if (setup_q_rd_req) begin
                expect_true(fid_q.size() != 0, "setup queue popped while empty");
                if (fid_q.size() != 0) begin
                    void'(fid_q.pop_front());
                end
            end

            if (noc_out_val && noc_out_rdy) begin
                expect_true(exp_conf.size() != 0, "confirm sent with no request outstanding");
                if (exp_conf.size() != 0) begin
                    conf = exp_conf.pop_front();
                    check_val("confirm flit", 64'(conf), 64'(noc_out_data));
                    rec.flowid       = conf.flowid;
                    rec.dir          = conf.dir;
                    rec.target_bytes = conf.target_bytes;
                    rec.last_conn    = conf.last_conn;
                    exp_launch.push_back(rec);
                end
            end

            if (app_mem_wr_req) begin
                expect_true(exp_launch.size() != 0, "launch without a confirmed connection");
                if (exp_launch.size() != 0) begin
                    rec = exp_launch.pop_front();
                    check_val("app mem addr", 64'(rec.flowid), 64'(app_mem_wr_addr));
                    check_val("app mem data", 64'({rec.target_bytes, rec.dir}),
                              64'(app_mem_wr_data));
                    check_val("send strobe", 64'(rec.dir == DIR_SEND), 64'(send_loop_q_wr_req));
                    check_val("recv strobe", 64'(rec.dir == DIR_RECV), 64'(recv_loop_q_wr_req));
                    if (rec.dir == DIR_SEND) begin
                        check_val("send entry", 64'({rec.flowid, rec.target_bytes}),
                                  64'(send_loop_q_wr_data));
                    end else begin
                        check_val("recv flowid", 64'(rec.flowid), 64'(recv_loop_q_wr_flowid));
                    end
                    exp_dir = rec.dir;
                    if (rec.last_conn) begin
                        done_exp = 1'b1;
                    end
                end
            end else begin
                check_val("send strobe", 64'd0, 64'(send_loop_q_wr_req));
                check_val("recv strobe", 64'd0, 64'(recv_loop_q_wr_req));
            end
            check_val("setup_done", 64'(done_exp), 64'(setup_done));
            check_val("bench_dir", 64'(exp_dir), 64'(bench_dir));
        end
    end

    task automatic make_flit(input logic is_req, input logic last, output setup_msg_t msg);
        logic [31:0] rnd;
        logic [31:0] rnd2;
        rnd  = $random(seed);
        rnd2 = $random(seed);
        if (is_req) begin
            msg.msg_type = SETUP_REQ;
        end else begin
            msg.msg_type = msg_type_e'((rnd[3:0] == 4'h1) ? 4'h0 : rnd[3:0]);
        end
        msg.flowid       = rnd[11:4];           // Ignored, the queue supplies the id
        msg.dir          = client_dir_e'(rnd[12]);
        msg.last_conn    = last;
        msg.target_bytes = rnd2;
        msg.padding      = rnd[13 +: MSG_PAD_W];
    endtask

    task automatic offer_flit(input setup_msg_t msg);
        int waited;
        waited      = 0;
        noc_in_val  = 1'b1;
        noc_in_data = msg;
        @(negedge clk);
        while (!in_fire && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("timed out waiting for the handler to take a flit");
            end else begin
                @(negedge clk);
            end
        end
        noc_in_val = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((fid_q.size() != 0 || exp_conf.size() != 0 || exp_launch.size() != 0)
               && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("timed out waiting for confirms and launches to drain");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic check_reset_state();
        start_test("reset_state");
        for (int i = 0; i < 3; i++) begin
            check_val("setup_q_rd_req", 64'd0, 64'(setup_q_rd_req));
            check_val("noc_out_val", 64'd0, 64'(noc_out_val));
            check_val("app_mem_wr_req", 64'd0, 64'(app_mem_wr_req));
            check_val("send_loop_q_wr_req", 64'd0, 64'(send_loop_q_wr_req));
            check_val("recv_loop_q_wr_req", 64'd0, 64'(recv_loop_q_wr_req));
            check_val("setup_done", 64'd0, 64'(setup_done));
            check_val("bench_dir", 64'(DIR_SEND), 64'(bench_dir));
            @(negedge clk);
        end
        finish_test();
    endtask

    // Requests with discarded flits mixed in
    task automatic run_stream(input string name, input logic backpressure,
                              input logic mark_last);
        setup_msg_t     msg;
        logic [31:0]    rnd;
        start_test(name);
        bp_on = backpressure;
        for (int i = 0; i < NUM_REQ; i++) begin
            rnd = $random(seed);
            fid_q.push_back(rnd[FLOWID_W-1:0]);
        end
        for (int i = 0; i < NUM_REQ && !timed_out; i++) begin
            rnd = $random(seed);
            repeat (rnd[5:4]) @(negedge clk);
            if (rnd[2:0] == 3'd0) begin
                make_flit(1'b0, rnd[3], msg);
                offer_flit(msg);
            end
            if (!timed_out) begin
                make_flit(1'b1, mark_last && (i == NUM_REQ - 1), msg);
                offer_flit(msg);
            end
        end
        wait_drain();
        if (!timed_out) begin
            repeat (4) @(negedge clk);
            check_val("setup_done at end", 64'(mark_last), 64'(setup_done));
        end
        bp_on = 1'b0;
        finish_test();
    endtask

    initial begin
        rst_n          = 1'b0;
        noc_in_val     = 1'b0;
        noc_in_data    = '0;
        noc_out_rdy    = 1'b1;
        setup_q_empty  = 1'b1;
        setup_q_flowid = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        run_stream("confirm_launch", 1'b0, 1'b0);
        if (!timed_out) begin
            run_stream("backpressure_completion", 1'b1, 1'b1);
        end

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
